//--- files.f
+incdir+verilog
verilog/audio_pkg.sv
verilog/i2s_timing.sv
verilog/i2s_rx.sv
verilog/mic_capture.sv
verilog/host_regs.sv
verilog/audio_store.sv
verilog/i2s_tx.sv
verilog/audio_engine.sv
tests/tb_audio_engine.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_audio_engine
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_audio_engine.sv
`timescale 1ns/100ps
`include "audio_params.svh"

module tb_audio_engine;

    localparam int TIMEOUT_CYCLES = 10 * 1024 + 2000;
    localparam int TABLE_FRAMES = 3;
    localparam int CHANNELS = `AUDIO_CHANNELS;
    localparam int SAMPLE_W = `AUDIO_SAMPLE_W;

    typedef struct packed {
        logic        we;
        logic [7:0]  region;
        logic [1:0]  index;
        logic [31:0] wdata;
        logic        ack_expected;
        logic [31:0] rdata;
    } reg_op_t;

    // Same layout as register 2
    typedef struct packed {
        logic [15:0] right;
        logic [15:0] left;
    } sample_pair_t;

    logic                         ck;
    logic                         reset;
    logic                         bus_cyc;
    logic                         bus_we;
    logic [31:0]                  bus_adr;
    logic [31:0]                  bus_dat;
    logic                         ack;
    logic [31:0]                  rdt;
    logic                         sck;
    logic                         ws;
    logic                         sd_out;
    logic [`AUDIO_CHANNELS/2-1:0] sd_in = '0;

    logic [15:0]  sample_tab [TABLE_FRAMES*CHANNELS];
    sample_pair_t out_tab [2];
    reg_op_t      reg_ops [6];
    logic [31:0]  lfsr_state = 32'd68730;
    int           mismatches = 0;
    int           failures = 0;
    int           cycle_count = 0;

    // I2S line monitor state
    logic         sck_prev;
    logic         ws_prev;
    logic         sck_seen;
    logic         ws_seen;
    int           sck_run;
    int           ws_run;
    int           bit_pos;
    int           src_frame;
    int           sink_frames;
    logic [15:0]  src_word;
    logic [15:0]  sink_word;
    logic [15:0]  sink_left;
    sample_pair_t sink_pair;

    audio_engine UUT (
        .ck(ck), .reset(reset), .bus_cyc(bus_cyc), .bus_we(bus_we),
        .bus_adr(bus_adr), .bus_dat(bus_dat), .ack(ack), .rdt(rdt),
        .sck(sck), .ws(ws), .sd_out(sd_out), .sd_in(sd_in)
    );

    initial begin
        ck = 1'b0;
        forever #5 ck = ~ck;
    end

    always @(posedge ck) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic next_random_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        end
        return out;
    endfunction

    function automatic logic [15:0] random_word();
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            w = {w[14:0], next_random_bit()};
        end
        return w;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [7:0] region, input logic [1:0] idx);
        return {region, 20'd0, idx, 2'b00};
    endfunction

    // RAM index is {channel, frame}
    function automatic logic [31:0] ram_addr(input logic [10:0] idx);
        return {`AUDIO_REGION_INPUT, 11'd0, idx, 2'b00};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, want);
        mismatches++;
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        failures++;
    endtask

    // Host holds cyc until ack, then releases one cycle later
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                              input logic ack_expected, output logic [31:0] rdata);
        int   waited;
        logic got_ack;
        waited = 0;
        got_ack = 1'b0;
        rdata = '0;
        @(posedge ck);
        #1;
        bus_cyc = 1'b1;
        bus_we = we;
        bus_adr = adr;
        bus_dat = wdata;
        while (!got_ack && waited < 8) begin
            @(posedge ck);
            #1;
            waited++;
            if (ack) begin
                got_ack = 1'b1;
                rdata = rdt;
            end
        end
        if (got_ack) begin
            @(posedge ck);
            #1;
            if (ack) begin
                report_failure($sformatf("ack held for two cycles at address %h", adr));
            end
        end
        bus_cyc = 1'b0;
        bus_we = 1'b0;
        bus_adr = '0;
        bus_dat = '0;
        if (ack_expected && !got_ack) begin
            report_failure($sformatf("no ack within 8 cycles for address %h", adr));
        end else if (!ack_expected && got_ack) begin
            report_failure($sformatf("unexpected ack for address %h", adr));
        end
    endtask

    // Source model, sink decoder and clock period checks, all sampled 1 ns after the edge
    always begin
        @(posedge ck);
        #1;
        if (reset) begin
            sck_prev = 1'b0;
            ws_prev = 1'b0;
            sck_seen = 1'b0;
            ws_seen = 1'b0;
            sck_run = 0;
            ws_run = 0;
            bit_pos = 0;
            src_frame = 0;
            sink_frames = 0;
            sink_word = '0;
            sink_left = '0;
            sink_pair = '0;
            sd_in = '0;
        end else begin
            sck_run++;
            ws_run++;
            if (sck !== sck_prev) begin
                if (sck_seen && sck_run != 8) begin
                    report_mismatch("sck level length", sck_run, 8);
                end
                sck_seen = 1'b1;
                sck_run = 0;
            end
            if (ws !== ws_prev) begin
                if (ws_seen && ws_run != 512) begin
                    report_mismatch("ws level length", ws_run, 512);
                end
                ws_seen = 1'b1;
                ws_run = 0;
            end
            // Falling sck starts a bit
            if (sck_prev && !sck) begin
                if (ws != ws_prev) begin
                    bit_pos = 0;
                    if (ws_prev) begin
                        sink_pair = {sink_word, sink_left};
                        sink_frames++;
                        src_frame++;
                    end else begin
                        sink_left = sink_word;
                    end
                end else begin
                    bit_pos++;
                end
                sd_in = '0;
                if (src_frame < TABLE_FRAMES && bit_pos >= 1 && bit_pos <= SAMPLE_W) begin
                    for (int n = 0; n < CHANNELS / 2; n++) begin
                        src_word = sample_tab[src_frame*CHANNELS + 2*n + (ws ? 1 : 0)];
                        sd_in[n] = src_word[SAMPLE_W - bit_pos];
                    end
                end
            end
            // Rising sck is mid-bit
            if (!sck_prev && sck && bit_pos >= 1 && bit_pos <= SAMPLE_W) begin
                sink_word = {sink_word[SAMPLE_W-2:0], sd_out};
            end
            sck_prev = sck;
            ws_prev = ws;
        end
    end

    initial begin
        logic [31:0]  data;
        logic [7:0]   count;
        logic [7:0]   expected_count;
        logic [10:0]  host_index;
        logic [15:0]  host_word;
        sample_pair_t prev_pair;
        int           base;
        reset = 1'b1;
        bus_cyc = 1'b0;
        bus_we = 1'b0;
        bus_adr = '0;
        bus_dat = '0;
        for (int i = 0; i < TABLE_FRAMES * CHANNELS; i++) begin
            sample_tab[i] = random_word();
        end
        for (int p = 0; p < 2; p++) begin
            out_tab[p].left = random_word();
            out_tab[p].right = random_word();
        end
        host_word = random_word();
        // Control holds frame in bits 9..2 and host_mode in bit 0
        reg_ops[0] = '{1'b1, `AUDIO_REGION_STATUS, 2'd0, {22'd0, 8'h3C, 1'b0, 1'b1}, 1'b1, 32'd0};
        reg_ops[1] = '{1'b0, `AUDIO_REGION_STATUS, 2'd0, 32'd0, 1'b1,
                       {22'd0, 8'h3C, 1'b0, 1'b1}};
        reg_ops[2] = '{1'b1, `AUDIO_REGION_STATUS, 2'd0, {22'd0, 8'hA5, 1'b0, 1'b0}, 1'b1, 32'd0};
        reg_ops[3] = '{1'b0, `AUDIO_REGION_STATUS, 2'd0, 32'd0, 1'b1,
                       {22'd0, 8'hA5, 1'b0, 1'b0}};
        reg_ops[4] = '{1'b0, `AUDIO_REGION_STATUS, 2'd2, 32'd0, 1'b1, 32'd0};
        reg_ops[5] = '{1'b0, 8'h55, 2'd0, 32'd0, 1'b0, 32'd0};

        repeat (8) begin
            @(posedge ck);
            #1;
            if (ack !== 1'b0) report_mismatch("ack", ack, 0);
            if (sck !== 1'b0) report_mismatch("sck", sck, 0);
            if (ws !== 1'b0) report_mismatch("ws", ws, 0);
            if (sd_out !== 1'b0) report_mismatch("sd_out", sd_out, 0);
        end
        reset = 1'b0;
        bus_access(1'b0, reg_addr(`AUDIO_REGION_STATUS, 2'd0), 32'd0, 1'b1, data);
        if (data !== 32'd0) report_mismatch("control after reset", data, 0);

        // Three table frames go out, then capture is frozen
        wait (src_frame == TABLE_FRAMES);
        repeat (16) @(posedge ck);
        bus_access(1'b1, reg_addr(`AUDIO_REGION_STATUS, 2'd0), 32'd1, 1'b1, data);
        bus_access(1'b0, reg_addr(`AUDIO_REGION_STATUS, 2'd1), 32'd0, 1'b1, data);
        count = data[7:0];
        expected_count = 8'd0 - 8'(TABLE_FRAMES);
        if (data !== {24'd0, expected_count}) report_mismatch("status", data, expected_count);
        for (int ch = 0; ch < CHANNELS; ch++) begin
            bus_access(1'b0, ram_addr({3'(ch), count}), 32'd0, 1'b1, data);
            if (data !== {16'd0, sample_tab[2*CHANNELS + ch]}) begin
                report_mismatch($sformatf("ram[%0d][%0d]", ch, count), data,
                                sample_tab[2*CHANNELS + ch]);
            end
            bus_access(1'b0, ram_addr({3'(ch), count + 8'd1}), 32'd0, 1'b1, data);
            if (data !== {16'd0, sample_tab[CHANNELS + ch]}) begin
                report_mismatch($sformatf("ram[%0d][%0d]", ch, count + 8'd1), data,
                                sample_tab[CHANNELS + ch]);
            end
        end

        // Channel 6 slot that the next capture burst would overwrite
        host_index = {3'd6, expected_count - 8'd1};
        bus_access(1'b1, ram_addr(host_index), {16'd0, host_word}, 1'b1, data);
        bus_access(1'b0, ram_addr(host_index), 32'd0, 1'b1, data);
        if (data !== {16'd0, host_word}) report_mismatch("host ram word", data, host_word);
        base = src_frame;
        wait (src_frame == base + 2);
        bus_access(1'b0, reg_addr(`AUDIO_REGION_STATUS, 2'd1), 32'd0, 1'b1, data);
        if (data !== {24'd0, expected_count}) begin
            report_mismatch("frozen status", data, expected_count);
        end
        bus_access(1'b0, ram_addr(host_index), 32'd0, 1'b1, data);
        if (data !== {16'd0, host_word}) report_mismatch("host ram word kept", data, host_word);

        // New pair is heard in the frame after the next start
        prev_pair = '0;
        for (int p = 0; p < 2; p++) begin
            bus_access(1'b1, reg_addr(`AUDIO_REGION_STATUS, 2'd2), out_tab[p], 1'b1, data);
            base = sink_frames;
            wait (sink_frames == base + 1);
            if (sink_pair !== prev_pair) report_mismatch("sd_out old pair", sink_pair, prev_pair);
            wait (sink_frames == base + 2);
            if (sink_pair !== out_tab[p]) report_mismatch("sd_out new pair", sink_pair, out_tab[p]);
            prev_pair = out_tab[p];
        end

        for (int i = 0; i < 6; i++) begin
            bus_access(reg_ops[i].we, reg_addr(reg_ops[i].region, reg_ops[i].index),
                       reg_ops[i].wdata, reg_ops[i].ack_expected, data);
            if (!reg_ops[i].we && reg_ops[i].ack_expected && data !== reg_ops[i].rdata) begin
                report_mismatch($sformatf("rdt of register op %0d", i), data, reg_ops[i].rdata);
            end
        end

        $display("Run complete: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Run stopped: %0d mismatches, %0d other errors", mismatches, failures);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- verilog/audio_engine.sv
`timescale 1ns/100ps
`include "audio_params.svh"

module audio_engine (
    input  logic                          ck,
    input  logic                          reset,
    input  logic                          bus_cyc,
    input  logic                          bus_we,
    input  logic [`AUDIO_BUS_W-1:0]       bus_adr,
    input  logic [`AUDIO_BUS_W-1:0]       bus_dat,
    output logic                          ack,
    output logic [`AUDIO_BUS_W-1:0]       rdt,
    output logic                          sck,
    output logic                          ws,
    output logic                          sd_out,
    input  logic [`AUDIO_CHANNELS/2-1:0]  sd_in
);

    audio_pkg::bus_req_t        bus;
    audio_pkg::i2s_timing_t     timing;
    audio_pkg::ctrl_t           ctrl;
    audio_pkg::audio_wr_t       cap_wr;
    audio_pkg::audio_wr_t       host_wr;
    logic [`AUDIO_FRAME_W-1:0]  frame_count;
    logic [`AUDIO_SAMPLE_W-1:0] ram_rdata;
    logic [`AUDIO_SAMPLE_W-1:0] left;
    logic [`AUDIO_SAMPLE_W-1:0] right;

    assign bus = {bus_cyc, bus_we, bus_adr, bus_dat};

    i2s_timing timing_gen (
        .ck(ck), .reset(reset), .sck(sck), .ws(ws), .timing(timing)
    );

    mic_capture capture (
        .ck(ck), .reset(reset), .timing(timing), .sd_in(sd_in),
        .ctrl(ctrl), .cap_wr(cap_wr), .frame_count(frame_count)
    );

    host_regs regs (
        .ck(ck), .reset(reset), .bus(bus), .ram_rdata(ram_rdata),
        .frame_count(frame_count), .ack(ack), .rdt(rdt), .ctrl(ctrl),
        .host_wr(host_wr), .left(left), .right(right)
    );

    // Read address comes straight from the RAM view of the bus address
    audio_store store (
        .ck(ck), .ctrl(ctrl), .cap_wr(cap_wr), .host_wr(host_wr),
        .raddr(bus.adr.ram_view.index), .rdata(ram_rdata)
    );

    i2s_tx tx (
        .ck(ck), .reset(reset), .timing(timing),
        .left(left), .right(right), .sd(sd_out)
    );

endmodule

//--- verilog/i2s_tx.sv
`timescale 1ns/100ps
`include "audio_params.svh"

module i2s_tx (
    input  logic                       ck,
    input  logic                       reset,
    input  audio_pkg::i2s_timing_t     timing,
    input  logic [`AUDIO_SAMPLE_W-1:0] left,
    input  logic [`AUDIO_SAMPLE_W-1:0] right,
    output logic                       sd
);

    localparam int HALF_W = `AUDIO_POSN_W - 1;

    logic [2*`AUDIO_SAMPLE_W-1:0] shift;
    logic [HALF_W-1:0]            half_posn;
    logic                         in_word;

    assign half_posn = timing.posn[HALF_W-1:0];
    assign in_word = (half_posn != '0) && (half_posn <= HALF_W'(`AUDIO_SAMPLE_W));

    always_ff @(posedge ck) begin
        if (reset) begin
            shift <= '0;
            sd    <= 1'b0;
        end else if (timing.start_of_frame) begin
            // Left goes out first, right follows in the upper half
            shift <= {left, right};
            sd    <= 1'b0;
        end else if (timing.bit_en) begin
            if (in_word) begin
                sd    <= shift[2*`AUDIO_SAMPLE_W-1];
                shift <= {shift[2*`AUDIO_SAMPLE_W-2:0], 1'b0};
            end else begin
                sd <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/audio_store.sv
`timescale 1ns/100ps
`include "audio_params.svh"

module audio_store (
    input  logic                       ck,
    input  audio_pkg::ctrl_t           ctrl,
    input  audio_pkg::audio_wr_t       cap_wr,
    input  audio_pkg::audio_wr_t       host_wr,
    input  logic [`AUDIO_RAM_W-1:0]    raddr,
    output logic [`AUDIO_SAMPLE_W-1:0] rdata
);

    localparam int DEPTH = `AUDIO_CHANNELS * `AUDIO_FRAMES;

    // 8 channels by 256 frames
    logic [`AUDIO_SAMPLE_W-1:0] mem [DEPTH];
    audio_pkg::audio_wr_t       wr;

    // Host mode hands the write port to the bus
    assign wr = ctrl.host_mode ? host_wr : cap_wr;

    always_ff @(posedge ck) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
        rdata <= mem[raddr];
    end

endmodule

//--- verilog/host_regs.sv
`timescale 1ns/100ps
`include "audio_params.svh"

module host_regs (
    input  logic                       ck,
    input  logic                       reset,
    input  audio_pkg::bus_req_t        bus,
    input  logic [`AUDIO_SAMPLE_W-1:0] ram_rdata,
    input  logic [`AUDIO_FRAME_W-1:0]  frame_count,
    output logic                       ack,
    output logic [`AUDIO_BUS_W-1:0]    rdt,
    output audio_pkg::ctrl_t           ctrl,
    output audio_pkg::audio_wr_t       host_wr,
    output logic [`AUDIO_SAMPLE_W-1:0] left,
    output logic [`AUDIO_SAMPLE_W-1:0] right
);

    localparam int BUS_W = `AUDIO_BUS_W;
    localparam int SAMPLE_W = `AUDIO_SAMPLE_W;

    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;
    localparam logic [1:0] REG_OUTPUT = 2'd2;

    logic             cyc_d;
    logic             new_req;
    logic             hit_status;
    logic             hit_input;
    logic             ack_status;
    logic             ack_input;
    logic [1:0]       reg_index;
    logic [BUS_W-1:0] status_rdt;

    // Rising edge of cyc marks a new request
    assign new_req    = bus.cyc && !cyc_d;
    assign hit_status = (bus.adr.reg_view.region == `AUDIO_REGION_STATUS);
    assign hit_input  = (bus.adr.reg_view.region == `AUDIO_REGION_INPUT);
    assign reg_index  = bus.adr.reg_view.index;

    always_ff @(posedge ck) begin
        if (reset) begin
            cyc_d      <= 1'b0;
            ack_status <= 1'b0;
            ack_input  <= 1'b0;
        end else begin
            cyc_d      <= bus.cyc;
            ack_status <= new_req && hit_status;
            ack_input  <= new_req && hit_input;
        end
    end

    assign ack = ack_status || ack_input;

    // Register writes land in the ack cycle
    always_ff @(posedge ck) begin
        if (reset) begin
            ctrl  <= '0;
            left  <= '0;
            right <= '0;
        end else if (ack_status && bus.we) begin
            case (reg_index)
                REG_CTRL: begin
                    ctrl.host_mode <= bus.dat[0];
                    ctrl.frame     <= bus.dat[`AUDIO_FRAME_W+1:2];
                end
                REG_OUTPUT: begin
                    left  <= bus.dat[SAMPLE_W-1:0];
                    right <= bus.dat[2*SAMPLE_W-1:SAMPLE_W];
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (reg_index)
            REG_CTRL:   status_rdt = BUS_W'({ctrl.frame, 1'b0, ctrl.host_mode});
            REG_STATUS: status_rdt = BUS_W'(frame_count);
            default:    status_rdt = '0;
        endcase
    end

    assign rdt = (ack_status && !bus.we) ? status_rdt :
                 (ack_input && !bus.we)  ? BUS_W'(ram_rdata) : '0;

    // RAM writes from the host only count in host mode
    assign host_wr.we   = ack_input && bus.we && ctrl.host_mode;
    assign host_wr.addr = bus.adr.ram_view.index;
    assign host_wr.data = bus.dat[SAMPLE_W-1:0];

    ack_one_cycle: assert property (
        @(posedge ck) disable iff (reset) ack |=> !ack
    ) else $error("ack lasted more than one cycle");

endmodule

//--- verilog/mic_capture.sv
`timescale 1ns/100ps
`include "audio_params.svh"

module mic_capture (
    input  logic                          ck,
    input  logic                          reset,
    input  audio_pkg::i2s_timing_t        timing,
    input  logic [`AUDIO_CHANNELS/2-1:0]  sd_in,
    input  audio_pkg::ctrl_t              ctrl,
    output audio_pkg::audio_wr_t          cap_wr,
    output logic [`AUDIO_FRAME_W-1:0]     frame_count
);

    localparam int LINES = `AUDIO_CHANNELS / 2;
    localparam logic [`AUDIO_CHAN_W-1:0] CHAN_LAST = `AUDIO_CHAN_W'(`AUDIO_CHANNELS - 1);

    logic [`AUDIO_SAMPLE_W-1:0] mic [`AUDIO_CHANNELS];
    logic [`AUDIO_CHAN_W-1:0]   chan;
    logic                       writing;

    // Line n carries channels 2n and 2n+1
    for (genvar n = 0; n < LINES; n++) begin : g_line
        i2s_rx rx (
            .ck     (ck),
            .reset  (reset),
            .timing (timing),
            .sd     (sd_in[n]),
            .left   (mic[2*n]),
            .right  (mic[2*n+1])
        );
    end

    always_ff @(posedge ck) begin
        if (reset) begin
            frame_count <= '0;
            chan        <= '0;
            writing     <= 1'b0;
        end else if (ctrl.host_mode) begin
            // Capture halts, any burst in flight is dropped
            writing <= 1'b0;
        end else if (timing.start_of_frame) begin
            frame_count <= frame_count - 1'b1;
            chan        <= '0;
            writing     <= 1'b1;
        end else if (writing) begin
            chan <= chan + 1'b1;
            if (chan == CHAN_LAST) begin
                writing <= 1'b0;
            end
        end
    end

    assign cap_wr.we   = writing && !ctrl.host_mode;
    assign cap_wr.addr = {chan, frame_count};
    assign cap_wr.data = mic[chan];

    // Host mode stops the burst and holds the frame counter
    no_capture_in_host_mode: assert property (
        @(posedge ck) disable iff (reset) ctrl.host_mode |=> !writing && $stable(frame_count)
    ) else $error("capture still running in host mode");

endmodule

//--- verilog/i2s_rx.sv
`timescale 1ns/100ps
`include "audio_params.svh"

module i2s_rx (
    input  logic                       ck,
    input  logic                       reset,
    input  audio_pkg::i2s_timing_t     timing,
    input  logic                       sd,
    output logic [`AUDIO_SAMPLE_W-1:0] left,
    output logic [`AUDIO_SAMPLE_W-1:0] right
);

    localparam int HALF_W = `AUDIO_POSN_W - 1;

    logic [HALF_W-1:0]          half_posn;
    logic                       in_word;
    logic [`AUDIO_SAMPLE_W-1:0] shift;

    assign half_posn = timing.posn[HALF_W-1:0];
    // Data bits sit in positions 1..16 of each half
    assign in_word = (half_posn != '0) && (half_posn <= HALF_W'(`AUDIO_SAMPLE_W));

    always_ff @(posedge ck) begin
        if (reset) begin
            shift <= '0;
            left  <= '0;
            right <= '0;
        end else begin
            if (timing.sample_en && in_word) begin
                shift <= {shift[`AUDIO_SAMPLE_W-2:0], sd};
            end
            // A new half begins, so the previous one is complete
            if (timing.bit_en && (half_posn == '0)) begin
                if (timing.posn[HALF_W]) begin
                    left <= shift;
                end else begin
                    right <= shift;
                end
            end
        end
    end

endmodule

//--- verilog/i2s_timing.sv
`timescale 1ns/100ps
`include "audio_params.svh"

module i2s_timing (
    input  logic                   ck,
    input  logic                   reset,
    output logic                   sck,
    output logic                   ws,
    output audio_pkg::i2s_timing_t timing
);

    localparam int DIV_W = $clog2(`AUDIO_I2S_DIVIDER);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`AUDIO_I2S_DIVIDER - 1);
    localparam logic [DIV_W-1:0] SCK_RISE = DIV_W'(`AUDIO_I2S_DIVIDER / 2 - 1);
    localparam logic [`AUDIO_POSN_W-1:0] POSN_LAST = '1;

    logic [DIV_W-1:0]               div;
    logic [`AUDIO_POSN_W-1:0]       posn;
    logic                           bit_en;
    logic                           frame_en;
    logic [`AUDIO_SAMPLE_DELAY-1:0] delay;

    always_ff @(posedge ck) begin
        if (reset) begin
            div      <= '0;
            posn     <= '0;
            bit_en   <= 1'b0;
            frame_en <= 1'b0;
            sck      <= 1'b0;
            delay    <= '0;
        end else begin
            bit_en   <= (div == DIV_LAST);
            frame_en <= (div == DIV_LAST) && (posn == POSN_LAST);
            delay    <= {delay[`AUDIO_SAMPLE_DELAY-2:0], bit_en};
            if (div == DIV_LAST) begin
                div  <= '0;
                posn <= posn + 1'b1;
            end else begin
                div <= div + 1'b1;
            end
            // High for the second half of each bit
            sck <= (div >= SCK_RISE) && (div != DIV_LAST);
        end
    end

    // Right channel in the upper half of the frame
    assign ws = posn[`AUDIO_POSN_W-1];

    assign timing.bit_en         = bit_en;
    assign timing.sample_en      = delay[`AUDIO_SAMPLE_DELAY-1];
    assign timing.start_of_frame = frame_en;
    assign timing.posn           = posn;

endmodule

//--- verilog/audio_pkg.sv
`include "audio_params.svh"

package audio_pkg;

    // Register access: region byte and a 2-bit register index
    typedef struct packed {
        logic [7:0]                          region;
        logic [`AUDIO_BUS_W-8-2-2-1:0]       unused;
        logic [1:0]                          index;
        logic [1:0]                          byte_sel;
    } reg_view_t;

    // RAM access: index is {channel, frame}
    typedef struct packed {
        logic [7:0]                          region;
        logic [`AUDIO_BUS_W-8-`AUDIO_RAM_W-2-1:0] unused;
        logic [`AUDIO_RAM_W-1:0]             index;
        logic [1:0]                          byte_sel;
    } ram_view_t;

    typedef union packed {
        reg_view_t reg_view;
        ram_view_t ram_view;
    } bus_addr_u;

    typedef struct packed {
        logic                    cyc;
        logic                    we;
        bus_addr_u               adr;
        logic [`AUDIO_BUS_W-1:0] dat;
    } bus_req_t;

    typedef struct packed {
        logic                     bit_en;
        logic                     sample_en;
        logic                     start_of_frame;
        logic [`AUDIO_POSN_W-1:0] posn;
    } i2s_timing_t;

    typedef struct packed {
        logic                       we;
        logic [`AUDIO_RAM_W-1:0]    addr;
        logic [`AUDIO_SAMPLE_W-1:0] data;
    } audio_wr_t;

    typedef struct packed {
        logic                      host_mode;
        logic [`AUDIO_FRAME_W-1:0] frame;
    } ctrl_t;

endpackage

//--- verilog/audio_params.svh
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// Sample and channel geometry
`define AUDIO_SAMPLE_W      16
`define AUDIO_CHANNELS      8
`define AUDIO_CHAN_W        3
`define AUDIO_FRAMES        256
`define AUDIO_FRAME_W       8
`define AUDIO_RAM_W         11

// I2S bit timing, in ck cycles
`define AUDIO_I2S_DIVIDER   16
`define AUDIO_POSN_W        6
`define AUDIO_SAMPLE_DELAY  5

// Host bus
`define AUDIO_REGION_STATUS 8'h62
`define AUDIO_REGION_INPUT  8'h64
`define AUDIO_BUS_W         32

`endif
